/* logic/mutative_pkg.sv */
package mutative_pkg;

    localparam int ADDR_W           = 16;
    localparam int NUM_LINES        = 8;
    localparam int LINE_W           = $clog2(NUM_LINES);       // Line index and LRU age width
    localparam int SWITCH_THRESHOLD = 800;
    localparam int CNT_W            = 12;
    localparam int MISS_PENALTY     = 4;
    localparam int TIMER_W          = $clog2(MISS_PENALTY + 2);

    typedef enum logic [1:0] {
        mode_dm   = 2'd0,                                       // 8 sets of 1 way
        mode_2way = 2'd1,                                       // 4 sets of 2 ways
        mode_4way = 2'd2,                                       // 2 sets of 4 ways
        mode_full = 2'd3                                        // 1 set of 8 ways
    } assoc_mode_e;

    typedef enum logic [2:0] {
        s_idle,
        s_update,
        s_waiting
    } ctrl_state_e;

    // Address bits that select the set in a given mode
    function automatic logic [LINE_W-1:0] set_mask(input assoc_mode_e mode);
        logic [LINE_W-1:0] mask;
        case (mode)
            mode_dm:   mask = 3'b111;
            mode_2way: mask = 3'b011;
            mode_4way: mask = 3'b001;
            default:   mask = 3'b000;
        endcase
        return mask;
    endfunction

endpackage

/* logic/mutative_control.sv */
`timescale 1ns/10ps

module mutative_control (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cpu_req,
    input  logic                      real_cache_valid,
    input  logic                      real_cache_hit,
    input  logic                      full_assoc_hit,
    input  logic                      real_cache_full,
    input  logic                      full_assoc_full,
    input  logic                      cache_ready,
    output mutative_pkg::assoc_mode_e setup
);

    import mutative_pkg::*;

    ctrl_state_e      state_q;
    ctrl_state_e      state_d;
    logic [CNT_W-1:0] switch_cnt_q;
    logic [CNT_W-1:0] switch_cnt_d;
    assoc_mode_e      setup_d;
    logic             conflict_miss;
    logic             capacity_miss;

    // A shadow hit means more ways would have kept the line
    assign conflict_miss = !real_cache_hit && (full_assoc_hit || !real_cache_full);
    assign capacity_miss = !real_cache_hit && !full_assoc_hit && real_cache_full
                           && full_assoc_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= s_idle;
            setup        <= mode_dm;
            switch_cnt_q <= '0;
        end else begin
            state_q      <= state_d;
            setup        <= setup_d;
            switch_cnt_q <= switch_cnt_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        setup_d      = setup;
        switch_cnt_d = switch_cnt_q;
        case (state_q)
            s_idle: begin
                if (switch_cnt_q >= CNT_W'(SWITCH_THRESHOLD)) begin
                    switch_cnt_d = '0;
                    if (setup != mode_full) begin
                        setup_d = assoc_mode_e'(setup + 2'd1);  // Never steps back down
                    end
                end
                if (cpu_req) begin
                    state_d = s_update;
                end
            end
            s_update: begin
                if (real_cache_valid) begin                     // Cold misses are skipped
                    if (conflict_miss) begin
                        switch_cnt_d = switch_cnt_q + CNT_W'(2);
                    end else if (capacity_miss && switch_cnt_q != '0) begin
                        switch_cnt_d = switch_cnt_q - CNT_W'(1);
                    end
                end
                state_d = s_waiting;
            end
            s_waiting: begin
                if (cache_ready) begin
                    state_d = s_idle;
                end
            end
            default: begin
                state_d = s_idle;
            end
        endcase
    end

endmodule

/* logic/real_cache_tags.sv */
`timescale 1ns/10ps

module real_cache_tags (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cpu_req,
    input  logic [mutative_pkg::ADDR_W-1:0] cpu_addr,
    input  mutative_pkg::assoc_mode_e       setup,
    output logic                            real_cache_valid,
    output logic                            real_cache_hit,
    output logic                            real_cache_full,
    output logic                            cache_ready
);

    import mutative_pkg::*;

    logic [ADDR_W-1:0]    tag_q [NUM_LINES];               // Whole line address kept per line
    logic [LINE_W-1:0]    age_q [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;
    assoc_mode_e          mode_q;
    logic [TIMER_W-1:0]   timer_q;
    logic                 busy_q;

    logic [LINE_W-1:0]    mask;
    logic [NUM_LINES-1:0] eff_valid;
    logic [NUM_LINES-1:0] in_set;
    logic [NUM_LINES-1:0] match;
    logic                 lookup_hit;
    logic [LINE_W-1:0]    hit_line;
    logic                 have_free;
    logic [LINE_W-1:0]    free_line;
    logic [LINE_W-1:0]    lru_line;
    logic [LINE_W-1:0]    lru_age;
    logic [LINE_W-1:0]    touch_line;

    // A line belongs to the addressed set when its index agrees on the set bits
    always_comb begin
        mask      = set_mask(setup);
        eff_valid = (setup != mode_q) ? '0 : valid_q;       // Mode change empties the array
        for (int i = 0; i < NUM_LINES; i++) begin
            in_set[i] = ((LINE_W'(i) ^ cpu_addr[LINE_W-1:0]) & mask) == '0;
            match[i]  = in_set[i] && eff_valid[i] && (tag_q[i] == cpu_addr);
        end
    end

    always_comb begin
        lookup_hit = |match;
        hit_line   = '0;
        have_free  = 1'b0;
        free_line  = '0;
        lru_line   = '0;
        lru_age    = '0;
        for (int i = NUM_LINES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_line = LINE_W'(i);
            end
            if (in_set[i] && !eff_valid[i]) begin
                have_free = 1'b1;
                free_line = LINE_W'(i);                     // Lowest free way wins
            end
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            if (in_set[i] && eff_valid[i] && age_q[i] >= lru_age) begin
                lru_age  = age_q[i];
                lru_line = LINE_W'(i);
            end
        end
        if (lookup_hit) begin
            touch_line = hit_line;
        end else if (have_free) begin
            touch_line = free_line;
        end else begin
            touch_line = lru_line;
        end
    end

    // Ages within a set stay a permutation of the valid ways
    always_ff @(posedge clk) begin
        if (cpu_req) begin
            tag_q[touch_line] <= cpu_addr;
            for (int i = 0; i < NUM_LINES; i++) begin
                if (LINE_W'(i) == touch_line) begin
                    age_q[i] <= '0;
                end else if (in_set[i] && eff_valid[i]
                             && (!eff_valid[touch_line] || age_q[i] < age_q[touch_line])) begin
                    age_q[i] <= age_q[i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q          <= '0;
            mode_q           <= mode_dm;
            busy_q           <= 1'b0;
            timer_q          <= '0;
            cache_ready      <= 1'b0;
            real_cache_valid <= 1'b0;
            real_cache_hit   <= 1'b0;
            real_cache_full  <= 1'b0;
        end else begin
            cache_ready <= 1'b0;
            if (cpu_req) begin
                mode_q           <= setup;
                valid_q          <= eff_valid | (NUM_LINES'(1) << touch_line);
                real_cache_valid <= |(eff_valid & in_set);
                real_cache_hit   <= lookup_hit;
                real_cache_full  <= &(eff_valid | ~in_set);
                busy_q           <= 1'b1;
                timer_q          <= lookup_hit ? TIMER_W'(1) : TIMER_W'(1 + MISS_PENALTY);
            end else if (busy_q) begin
                if (timer_q == '0) begin
                    cache_ready <= 1'b1;                    // Refill is only a delay here
                    busy_q      <= 1'b0;
                end else begin
                    timer_q <= timer_q - 1'b1;
                end
            end
        end
    end

endmodule

/* logic/shadow_assoc_tags.sv */
`timescale 1ns/10ps

module shadow_assoc_tags (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cpu_req,
    input  logic [mutative_pkg::ADDR_W-1:0] cpu_addr,
    output logic                            full_assoc_hit,
    output logic                            full_assoc_full
);

    import mutative_pkg::*;

    logic [ADDR_W-1:0]    tag_q [NUM_LINES];
    logic [LINE_W-1:0]    age_q [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;

    logic [NUM_LINES-1:0] match;
    logic                 lookup_hit;
    logic [LINE_W-1:0]    hit_line;
    logic                 have_free;
    logic [LINE_W-1:0]    free_line;
    logic [LINE_W-1:0]    lru_line;
    logic [LINE_W-1:0]    lru_age;
    logic [LINE_W-1:0]    touch_line;

    always_comb begin
        hit_line  = '0;
        have_free = 1'b0;
        free_line = '0;
        lru_line  = '0;
        lru_age   = '0;
        for (int i = 0; i < NUM_LINES; i++) begin
            match[i] = valid_q[i] && (tag_q[i] == cpu_addr);
        end
        lookup_hit = |match;
        for (int i = NUM_LINES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_line = LINE_W'(i);
            end
            if (!valid_q[i]) begin
                have_free = 1'b1;
                free_line = LINE_W'(i);
            end
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            if (valid_q[i] && age_q[i] >= lru_age) begin
                lru_age  = age_q[i];
                lru_line = LINE_W'(i);
            end
        end
        if (lookup_hit) begin
            touch_line = hit_line;
        end else if (have_free) begin
            touch_line = free_line;
        end else begin
            touch_line = lru_line;
        end
    end

    // Same recency rule as the real cache in mode_full
    always_ff @(posedge clk) begin
        if (cpu_req) begin
            tag_q[touch_line] <= cpu_addr;
            for (int i = 0; i < NUM_LINES; i++) begin
                if (LINE_W'(i) == touch_line) begin
                    age_q[i] <= '0;
                end else if (valid_q[i]
                             && (!valid_q[touch_line] || age_q[i] < age_q[touch_line])) begin
                    age_q[i] <= age_q[i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q         <= '0;
            full_assoc_hit  <= 1'b0;
            full_assoc_full <= 1'b0;
        end else if (cpu_req) begin
            valid_q         <= valid_q | (NUM_LINES'(1) << touch_line);
            full_assoc_hit  <= lookup_hit;
            full_assoc_full <= &valid_q;                    // Occupancy before this fill
        end
    end

endmodule

/* logic/mutative_cache_top.sv */
`timescale 1ns/10ps

module mutative_cache_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cpu_req,
    input  logic [mutative_pkg::ADDR_W-1:0] cpu_addr,
    output logic                            ready,
    output logic                            hit,
    output mutative_pkg::assoc_mode_e       setup
);

    logic real_cache_valid;
    logic real_cache_hit;
    logic real_cache_full;
    logic cache_ready;
    logic full_assoc_hit;
    logic full_assoc_full;

    real_cache_tags u_real_cache (
        .clk              (clk),
        .rst              (rst),
        .cpu_req          (cpu_req),
        .cpu_addr         (cpu_addr),
        .setup            (setup),
        .real_cache_valid (real_cache_valid),
        .real_cache_hit   (real_cache_hit),
        .real_cache_full  (real_cache_full),
        .cache_ready      (cache_ready)
    );

    shadow_assoc_tags u_shadow (
        .clk             (clk),
        .rst             (rst),
        .cpu_req         (cpu_req),
        .cpu_addr        (cpu_addr),
        .full_assoc_hit  (full_assoc_hit),
        .full_assoc_full (full_assoc_full)
    );

    mutative_control u_control (
        .clk              (clk),
        .rst              (rst),
        .cpu_req          (cpu_req),
        .real_cache_valid (real_cache_valid),
        .real_cache_hit   (real_cache_hit),
        .full_assoc_hit   (full_assoc_hit),
        .real_cache_full  (real_cache_full),
        .full_assoc_full  (full_assoc_full),
        .cache_ready      (cache_ready),
        .setup            (setup)
    );

    assign ready = cache_ready;
    assign hit   = real_cache_hit;                          // Held until the next request

endmodule

/* dv/mutative_cache_model.sv */
package mutative_cache_model;

    import mutative_pkg::*;

    logic [ADDR_W-1:0] real_lines [$];                      // Most recently used first
    logic [ADDR_W-1:0] shadow_lines [$];
    assoc_mode_e       model_mode;
    int                model_cnt;

    function automatic void reset_model();
        real_lines.delete();
        shadow_lines.delete();
        model_mode = mode_dm;
        model_cnt  = 0;
    endfunction

    // One lookup in an LRU store of the given shape, with refill on a miss
    function automatic bit lru_touch(ref logic [ADDR_W-1:0] lines [$],
                                     input logic [ADDR_W-1:0] addr,
                                     input int sets,
                                     input int ways,
                                     output bit set_valid,
                                     output bit set_full);
        int members;
        int victim;
        int found;
        members = 0;
        victim  = -1;
        found   = -1;
        for (int i = 0; i < lines.size(); i++) begin
            if (int'(lines[i]) % sets == int'(addr) % sets) begin
                members++;
                victim = i;                                 // Oldest member seen last
                if (lines[i] == addr) begin
                    found = i;
                end
            end
        end
        set_valid = members > 0;
        set_full  = members == ways;
        if (found >= 0) begin
            lines.delete(found);
        end else if (members == ways) begin
            lines.delete(victim);
        end
        lines.push_front(addr);
        return found >= 0;
    endfunction

    // Predicts the real hit and moves the switch counter and mode on
    function automatic bit model_access(input logic [ADDR_W-1:0] addr);
        bit real_hit;
        bit real_valid;
        bit real_full;
        bit shadow_hit;
        bit shadow_valid;
        bit shadow_full;
        int m;
        m          = int'(model_mode);
        real_hit   = lru_touch(real_lines, addr, NUM_LINES >> m, 1 << m, real_valid, real_full);
        shadow_hit = lru_touch(shadow_lines, addr, 1, NUM_LINES, shadow_valid, shadow_full);
        if (real_valid && !real_hit) begin
            if (shadow_hit || !real_full) begin
                model_cnt += 2;                             // Conflict miss
            end else if (shadow_full && model_cnt > 0) begin
                model_cnt -= 1;
            end
        end
        if (model_cnt >= SWITCH_THRESHOLD) begin
            model_cnt = 0;
            if (model_mode != mode_full) begin
                model_mode = assoc_mode_e'(m + 1);
                real_lines.delete();                        // New organisation starts empty
            end
        end
        return real_hit;
    endfunction

endpackage

/* dv/mutative_cache_tb.sv */
`timescale 1ns/10ps

module mutative_cache_tb;

    import mutative_pkg::*;
    import mutative_cache_model::*;

    localparam int CLK_PERIOD = 4;
    localparam int CAP_REQS   = 48;
    localparam int RAND_REQS  = 200;
    localparam int STEP_REQS  = SWITCH_THRESHOLD / 2 + 24;
    localparam int FULL_REQS  = 64;
    localparam int TOTAL_REQS = CAP_REQS + RAND_REQS + 3 * (STEP_REQS + 1) + FULL_REQS;
    localparam int REQ_CYCLES = 5 + MISS_PENALTY;           // Request, refill, ready, idle gap

    logic              clk;
    logic              rst;
    logic              cpu_req;
    logic [ADDR_W-1:0] cpu_addr;
    logic              ready;
    logic              hit;
    assoc_mode_e       setup;

    logic [15:0]       lfsr;
    bit                pending;
    int                wait_cyc;
    int                exp_lat;
    bit                exp_hit;
    assoc_mode_e       exp_setup;
    logic [CNT_W-1:0]  exp_cnt;

    mutative_cache_top UUT (
        .clk      (clk),
        .rst      (rst),
        .cpu_req  (cpu_req),
        .cpu_addr (cpu_addr),
        .ready    (ready),
        .hit      (hit),
        .setup    (setup)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TOTAL_REQS * REQ_CYCLES * CLK_PERIOD + 400);
        $display("Watchdog expired at %0t, controller in %s", $time,
                 UUT.u_control.state_q.name());
        $display("Test failed");
        $fatal(1);
    end

    function automatic void report_mismatch(input string name, input int expected,
                                            input int actual);
        $display("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual);
        $display("Test failed");
        $fatal(1);
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_line(output logic [ADDR_W-1:0] addr);
        addr = '0;
        for (int i = 0; i < 4; i++) begin
            lfsr    = lfsr_next(lfsr);
            addr[i] = lfsr[0];
        end
    endtask

    // wait_cyc set after edge E+k is seen by the assertions at edge E+k+1
    task automatic access(input logic [ADDR_W-1:0] addr);
        @(posedge clk);
        #1;
        exp_setup = model_mode;
        exp_cnt   = CNT_W'(model_cnt);
        exp_hit   = model_access(addr);
        exp_lat   = exp_hit ? 2 : 2 + MISS_PENALTY;
        cpu_req   = 1'b1;
        cpu_addr  = addr;
        @(posedge clk);
        #1;
        cpu_req  = 1'b0;
        pending  = 1'b1;
        wait_cyc = 0;
        while (!ready) begin
            @(posedge clk);
            #1;
            wait_cyc++;
            if (wait_cyc > exp_lat + 4) begin
                $display("No ready %0d cycles after the request to %h, controller in %s",
                         wait_cyc, addr, UUT.u_control.state_q.name());
                $display("Test failed");
                $fatal(1);
            end
        end
        @(posedge clk);
        #1;
        pending = 1'b0;
    endtask

    // One line more than the ways, all in set 0, so LRU always evicts the next one needed
    task automatic conflict_stream(input int ways, input int count, input bit until_step,
                                   output logic [ADDR_W-1:0] last_addr);
        int          sets;
        int          n;
        assoc_mode_e start;
        sets      = NUM_LINES / ways;
        start     = model_mode;
        n         = 0;
        last_addr = '0;
        while (n < count && !(until_step && model_mode != start)) begin
            last_addr = ADDR_W'((n % (ways + 1)) * sets);
            access(last_addr);
            n++;
        end
    endtask

    a_idle_ready: assert property (@(posedge clk) disable iff (rst) !pending |-> !ready)
        else report_mismatch("ready", 0, int'($sampled(ready)));

    a_ready_time: assert property (@(posedge clk) disable iff (rst)
                                   pending |-> ready == (wait_cyc == exp_lat))
        else report_mismatch("ready", int'($sampled(wait_cyc == exp_lat)), int'($sampled(ready)));

    a_hit: assert property (@(posedge clk) disable iff (rst) (pending && ready) |-> hit == exp_hit)
        else report_mismatch("hit", int'($sampled(exp_hit)), int'($sampled(hit)));

    a_setup: assert property (@(posedge clk) disable iff (rst) cpu_req |-> setup == exp_setup)
        else report_mismatch("setup", int'($sampled(exp_setup)), int'($sampled(setup)));

    a_counter: assert property (@(posedge clk) disable iff (rst)
                                cpu_req |-> UUT.u_control.switch_cnt_q == exp_cnt)
        else report_mismatch("switch_cnt_q", int'($sampled(exp_cnt)),
                             int'($sampled(UUT.u_control.switch_cnt_q)));

    initial begin : main
        logic [ADDR_W-1:0] addr;
        cpu_req   = 1'b0;
        cpu_addr  = '0;
        rst       = 1'b1;
        pending   = 1'b0;
        wait_cyc  = 0;
        exp_lat   = 0;
        exp_hit   = 1'b0;
        exp_setup = mode_dm;
        exp_cnt   = '0;
        lfsr      = 16'd84;
        reset_model();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (setup == mode_dm) else report_mismatch("setup", int'(mode_dm), int'(setup));
        assert (!ready) else report_mismatch("ready", 0, int'(ready));

        // Sixteen lines overflow both stores, so real misses are capacity misses
        for (int i = 0; i < CAP_REQS; i++) begin
            access(ADDR_W'(i % 16));
        end
        assert (setup == mode_dm) else report_mismatch("setup", int'(mode_dm), int'(setup));

        for (int i = 0; i < RAND_REQS; i++) begin
            random_line(addr);
            access(addr);
        end

        for (int m = 0; m < 3; m++) begin
            conflict_stream(1 << m, STEP_REQS, 1'b1, addr);
            @(posedge clk);
            #1;
            assert (setup == assoc_mode_e'(m + 1))
                else report_mismatch("setup", m + 1, int'(setup));
            access(addr);                                   // Last line filled is gone after the flush
        end

        conflict_stream(NUM_LINES, FULL_REQS, 1'b0, addr);
        @(posedge clk);
        #1;
        assert (setup == mode_full) else report_mismatch("setup", int'(mode_full), int'(setup));

        $display("Test passed");
        $finish;
    end

endmodule

/* tb.f */
logic/mutative_pkg.sv
logic/mutative_control.sv
logic/real_cache_tags.sv
logic/shadow_assoc_tags.sv
logic/mutative_cache_top.sv
dv/mutative_cache_model.sv
dv/mutative_cache_tb.sv

/* Makefile */
SIM       ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       ?= mutative_cache_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
